// File: source/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Requesters on the shared bus
`define BUS_NUM_SENDERS 11

// Receivers addressed by a 4-bit destination
`define BUS_NUM_RECEIVERS 9

// Width of a sender or receiver number
`define BUS_ID_WIDTH 4

// Pending requests between collector and arbiter
`define BUS_QUEUE_DEPTH 4

`endif

// File: source/agentPkg.sv
`include "bus_cfg.svh"

package agentPkg;

    // Higher index wins arbitration
    typedef enum logic [`BUS_ID_WIDTH-1:0] {
        sndBank3 = 0,
        sndBank2,
        sndBank1,
        sndBank0,
        sndDcOddWr,   // Data cache odd write
        sndDcEvenWr,  // Data cache even write
        sndDcOddRd,   // Data cache odd read
        sndDcEvenRd,  // Data cache even read
        sndIcOddRd,   // Instruction cache odd read
        sndIcEvenRd,  // Instruction cache even read
        sndDma
    } senderId_t;

    // Codes 9 to 15 name no receiver
    typedef enum logic [`BUS_ID_WIDTH-1:0] {
        rcvIcEven = 0,
        rcvIcOdd,
        rcvDcEven,
        rcvDcOdd,
        rcvBank0,
        rcvBank1,
        rcvBank2,
        rcvBank3,
        rcvDma
    } receiverId_t;

    // One bit per agent, indexed by its number
    typedef logic [`BUS_NUM_SENDERS-1:0] senderVec_t;
    typedef logic [`BUS_NUM_RECEIVERS-1:0] receiverVec_t;

endpackage

// File: source/busPkg.sv
package busPkg;

    // One queued transfer request
    typedef struct packed {
        agentPkg::senderId_t   sender;  // Who gets the grant
        agentPkg::receiverId_t dest;    // Who gets the recv strobe
    } busReq_t;

    typedef enum logic {
        arbIdle,
        arbBusy  // A sender owns the bus until it releases
    } arbState_t;

endpackage

// File: source/reqQueue.sv
`timescale 1ns/1ps

module reqQueue #(
    parameter type ENTRY_T = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   wrEn,
    input  ENTRY_T wrData,
    input  logic   pop,
    output ENTRY_T head,
    output logic   notEmpty,
    output logic   full
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    ENTRY_T            mem [DEPTH];
    logic [PtrW-1:0]   rdPtr;
    logic [PtrW-1:0]   wrPtr;
    logic [CntW-1:0]   count;
    logic              doWr;
    logic              doPop;

    assign notEmpty = (count != '0);
    assign full = (count == CntW'(DEPTH));
    assign head = mem[rdPtr];

    assign doWr = wrEn && !full;
    assign doPop = pop && notEmpty;

    always_ff @(posedge clk) begin
        if (doWr) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doWr) begin
                wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // Any depth wraps
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWr, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    noOverflow: assert property (
        @(posedge clk) disable iff (!rstN)
        wrEn |-> !full
    ) else $error("reqQueue: write while full");

    noUnderflow: assert property (
        @(posedge clk) disable iff (!rstN)
        pop |-> notEmpty
    ) else $error("reqQueue: pop while empty");

endmodule

// File: source/reqCollect.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module reqCollect (
    input  logic                                         clk,
    input  logic                                         rstN,
    input  agentPkg::senderVec_t                         req,
    input  agentPkg::receiverId_t [`BUS_NUM_SENDERS-1:0] reqDest,
    input  logic                                         full,
    output agentPkg::senderVec_t                         ack,
    output logic                                         wrEn,
    output busPkg::busReq_t                              wrData
);

    agentPkg::senderVec_t      pending;
    logic [`BUS_ID_WIDTH-1:0]  winIdx;
    logic                      found;

    assign pending = req & ~ack;  // Acked sender drops req in this cycle

    // Priority encoder over the pending requests
    always_comb begin
        winIdx = '0;
        found = 1'b0;
        for (int i = 0; i < `BUS_NUM_SENDERS; i++) begin
            if (pending[i]) begin
                winIdx = i[`BUS_ID_WIDTH-1:0];  // Later hit has higher priority
                found = 1'b1;
            end
        end
    end

    // Queue write lands on the same edge that raises ack
    assign wrEn = found && !full;
    assign wrData = '{sender: agentPkg::senderId_t'(winIdx), dest: reqDest[winIdx]};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= '0;
        end else begin
            ack <= '0;
            if (wrEn) begin
                ack[winIdx] <= 1'b1;  // Single cycle pulse
            end
        end
    end

    // At most one sender is acknowledged per cycle
    ackOneHot: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0(ack)
    ) else $error("reqCollect: more than one ack at once");

    // The queue's full flag must hold back every write
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (!rstN)
        full |-> !wrEn
    ) else $error("reqCollect: write attempted into a full queue");

endmodule

// File: source/busArbiter.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module busArbiter (
    input  logic                   clk,
    input  logic                   rstN,
    input  busPkg::busReq_t        head,
    input  logic                   notEmpty,
    input  agentPkg::receiverVec_t free,
    input  agentPkg::senderVec_t   rel,
    output logic                   pop,
    output agentPkg::senderVec_t   grant,
    output agentPkg::receiverVec_t recv
);

    busPkg::arbState_t state;
    busPkg::busReq_t   owner;
    logic              headFree;
    logic              ownerRel;

    // Out of range codes never read as free
    assign headFree = (head.dest < `BUS_NUM_RECEIVERS) && free[head.dest];

    assign pop = (state == busPkg::arbIdle) && notEmpty && headFree;
    assign ownerRel = rel[owner.sender];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= busPkg::arbIdle;
        end else begin
            case (state)
                busPkg::arbIdle: begin
                    if (pop) begin
                        state <= busPkg::arbBusy;
                    end
                end
                busPkg::arbBusy: begin
                    if (ownerRel) begin
                        state <= busPkg::arbIdle;  // Next pop one edge later at the earliest
                    end
                end
                default: state <= busPkg::arbIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            owner <= head;  // Held for the whole transfer
        end
    end

    // Levels come straight from the state and owner registers
    always_comb begin
        grant = '0;
        recv = '0;
        if (state == busPkg::arbBusy) begin
            grant[owner.sender] = 1'b1;
            recv[owner.dest] = 1'b1;
        end
    end

    grantOneHot: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0(grant)
    ) else $error("busArbiter: more than one grant");

    recvOneHot: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0(recv)
    ) else $error("busArbiter: more than one recv");

    // Entries come from the collector and must name a real receiver
    validDest: assert property (
        @(posedge clk) disable iff (!rstN)
        notEmpty |-> (head.dest < `BUS_NUM_RECEIVERS)
    ) else $error("busArbiter: queue head has an invalid destination");

endmodule

// File: source/busTop.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module busTop (
    input  logic                                         clk,
    input  logic                                         rstN,
    input  agentPkg::senderVec_t                         req,
    input  agentPkg::receiverId_t [`BUS_NUM_SENDERS-1:0] reqDest,
    input  agentPkg::receiverVec_t                       free,
    input  agentPkg::senderVec_t                         rel,
    output agentPkg::senderVec_t                         ack,
    output agentPkg::senderVec_t                         grant,
    output agentPkg::receiverVec_t                       recv
);

    logic            wrEn;
    busPkg::busReq_t wrData;
    logic            full;
    busPkg::busReq_t head;
    logic            notEmpty;
    logic            pop;

    reqCollect i_collect (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .reqDest (reqDest),
        .full    (full),
        .ack     (ack),
        .wrEn    (wrEn),
        .wrData  (wrData)
    );

    reqQueue #(
        .ENTRY_T (busPkg::busReq_t),
        .DEPTH   (`BUS_QUEUE_DEPTH)
    ) i_queue (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .wrData   (wrData),
        .pop      (pop),
        .head     (head),
        .notEmpty (notEmpty),
        .full     (full)
    );

    busArbiter i_arbiter (
        .clk      (clk),
        .rstN     (rstN),
        .head     (head),
        .notEmpty (notEmpty),
        .free     (free),
        .rel      (rel),
        .pop      (pop),
        .grant    (grant),
        .recv     (recv)
    );

endmodule

// File: tb/busTests.svh
task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("FAIL at time %0d ns: %s = 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
    end
endtask

task automatic flagError(input string msg);
    errors++;
    $display("ERROR at time %0d ns: %s", $time, msg);
endtask

function automatic int randBelow(input int n);
    int unsigned r;
    r = $random(seed);
    return r % n;
endfunction

function automatic int oneHotIndex(input logic [31:0] vec);
    int idx;
    idx = -1;
    for (int i = 0; i < 32; i++) begin
        if (vec[i]) begin
            idx = i;
        end
    end
    return idx;
endfunction

task automatic raiseReq(input int s, input int d);
    req[s] = 1'b1;
    reqDest[s] = agentPkg::receiverId_t'(d);
    outstanding[s] = 1'b1;
    raisedCount++;
endtask

// Waits until nothing is requested, queued or granted
task automatic waitDrained(input int limit);
    bit drained;
    drained = 1'b0;
    for (int n = 0; n < limit && !drained; n++) begin
        @(negedge clk);
        drained = (req == '0) && (ack == '0) && (grant == '0) && (expQ.size() == 0);
    end
    if (!drained) begin
        flagError($sformatf("the bus was still busy after %0d cycles", limit));
    end
endtask

task automatic checkGrantOrder();
    checkValue("number of grants", grantLog.size(), expOrder.size());
    for (int k = 0; k < expOrder.size() && k < grantLog.size(); k++) begin
        checkValue($sformatf("granted sender %0d", k), grantLog[k], expOrder[k]);
    end
endtask

task automatic testReset();
    @(negedge clk);
    checkValue("ack", ack, 0);
    checkValue("grant", grant, 0);
    checkValue("recv", recv, 0);
endtask

task automatic testSingle();
    int s;
    int d;
    s = agentPkg::sndDcEvenRd;
    d = agentPkg::rcvBank1;
    autoRelease = 1'b0;
    @(negedge clk);
    free = '1;
    raiseReq(s, d);
    @(negedge clk);
    checkValue("ack", ack, 32'd1 << s);
    checkValue("grant", grant, 0);
    @(negedge clk);
    checkValue("ack", ack, 0);
    checkValue("grant", grant, 32'd1 << s);
    checkValue("recv", recv, 32'd1 << d);
    repeat (3) begin
        @(negedge clk);
        checkValue("grant", grant, 32'd1 << s);  // Held until rel
        checkValue("recv", recv, 32'd1 << d);
    end
    rel[s] = 1'b1;
    @(negedge clk);
    checkValue("grant", grant, 0);
    checkValue("recv", recv, 0);
    rel[s] = 1'b0;
endtask

task automatic testPriority();
    autoRelease = 1'b1;
    randomRel = 1'b0;
    relWait = 1;
    grantLog.delete();
    expOrder.delete();
    @(negedge clk);
    free = '1;
    raiseReq(agentPkg::sndBank3, agentPkg::rcvBank3);
    raiseReq(agentPkg::sndBank0, agentPkg::rcvIcOdd);
    raiseReq(agentPkg::sndDcEvenRd, agentPkg::rcvDcEven);
    raiseReq(agentPkg::sndDma, agentPkg::rcvDma);
    expOrder.push_back(agentPkg::sndDma);  // Highest index first
    expOrder.push_back(agentPkg::sndDcEvenRd);
    expOrder.push_back(agentPkg::sndBank0);
    expOrder.push_back(agentPkg::sndBank3);
    for (int k = 0; k < 4; k++) begin
        @(negedge clk);
        checkValue("ack", ack, 32'd1 << expOrder[k]);
    end
    waitDrained(WaitLimit);
    checkGrantOrder();
endtask

task automatic testBusyReceiver();
    autoRelease = 1'b1;
    randomRel = 1'b0;
    relWait = 2;
    grantLog.delete();
    expOrder.delete();
    @(negedge clk);
    free = '1;
    free[agentPkg::rcvBank2] = 1'b0;
    raiseReq(agentPkg::sndDcEvenWr, agentPkg::rcvBank2);
    @(negedge clk);
    checkValue("ack", ack, 32'd1 << agentPkg::sndDcEvenWr);
    raiseReq(agentPkg::sndBank1, agentPkg::rcvIcEven);  // Free, but queued behind
    @(negedge clk);
    checkValue("ack", ack, 32'd1 << agentPkg::sndBank1);
    repeat (6) begin
        @(negedge clk);
        checkValue("grant", grant, 0);
    end
    free[agentPkg::rcvBank2] = 1'b1;
    @(negedge clk);
    checkValue("grant", grant, 32'd1 << agentPkg::sndDcEvenWr);
    checkValue("recv", recv, 32'd1 << agentPkg::rcvBank2);
    expOrder.push_back(agentPkg::sndDcEvenWr);
    expOrder.push_back(agentPkg::sndBank1);
    waitDrained(WaitLimit);
    checkGrantOrder();
endtask

task automatic testBackPressure();
    autoRelease = 1'b1;
    randomRel = 1'b0;
    relWait = 1;
    grantLog.delete();
    expOrder.delete();
    @(negedge clk);
    free = '0;
    raiseReq(agentPkg::sndIcEvenRd, agentPkg::rcvDcEven);
    raiseReq(agentPkg::sndIcOddRd, agentPkg::rcvBank1);
    raiseReq(agentPkg::sndDcOddRd, agentPkg::rcvIcOdd);
    raiseReq(agentPkg::sndDcOddWr, agentPkg::rcvDma);
    raiseReq(agentPkg::sndBank2, agentPkg::rcvBank3);
    expOrder.push_back(agentPkg::sndIcEvenRd);
    expOrder.push_back(agentPkg::sndIcOddRd);
    expOrder.push_back(agentPkg::sndDcOddRd);
    expOrder.push_back(agentPkg::sndDcOddWr);
    for (int k = 0; k < `BUS_QUEUE_DEPTH; k++) begin
        @(negedge clk);
        checkValue("ack", ack, 32'd1 << expOrder[k]);
    end
    repeat (4) begin
        @(negedge clk);
        checkValue("ack", ack, 0);  // Queue full
        checkValue("req of bank2", req[agentPkg::sndBank2], 1);
    end
    free[agentPkg::rcvDcEven] = 1'b1;
    @(negedge clk);
    checkValue("grant", grant, 32'd1 << agentPkg::sndIcEvenRd);
    checkValue("ack", ack, 0);
    @(negedge clk);
    checkValue("ack", ack, 32'd1 << agentPkg::sndBank2);
    free = '1;
    expOrder.push_back(agentPkg::sndBank2);
    waitDrained(WaitLimit);
    checkGrantOrder();
endtask

task automatic testRandom();
    int s;
    int d;
    for (int i = 0; i < 64; i++) begin
        relDelays[i] = randBelow(4);
    end
    autoRelease = 1'b1;
    randomRel = 1'b1;
    grantLog.delete();
    raisedCount = 0;
    for (int cyc = 0; cyc < RandomCycles; cyc++) begin
        @(negedge clk);
        for (int r = 0; r < `BUS_NUM_RECEIVERS; r++) begin
            free[r] = (randBelow(4) != 0);
        end
        if (randBelow(2) == 0) begin
            s = randBelow(`BUS_NUM_SENDERS);
            d = randBelow(`BUS_NUM_RECEIVERS);
            if (!outstanding[s]) begin
                raiseReq(s, d);  // One open request per sender
            end
        end
    end
    @(negedge clk);
    free = '1;
    waitDrained(DrainLimit);
    checkValue("number of grants", grantLog.size(), raisedCount);
    checkValue("outstanding", outstanding, 0);
    randomRel = 1'b0;
endtask

// File: tb/busTb.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module busTb;

    localparam int ClkPeriod = 100;
    localparam int ResetCycles = 4;
    localparam int WaitLimit = 40;  // Drain limit of a directed test
    localparam int RandomCycles = 300;
    localparam int DrainLimit = 150;
    localparam int TestBudget = ResetCycles + 2 + 12 + (5 + WaitLimit) + (14 + WaitLimit)
                                + (15 + WaitLimit) + (RandomCycles + 1 + DrainLimit);
    localparam int MarginCycles = 100;

    logic                                         clk;
    logic                                         rstN;
    agentPkg::senderVec_t                         req;
    agentPkg::receiverId_t [`BUS_NUM_SENDERS-1:0] reqDest;
    agentPkg::receiverVec_t                       free;
    agentPkg::senderVec_t                         rel;
    agentPkg::senderVec_t                         ack;
    agentPkg::senderVec_t                         grant;
    agentPkg::receiverVec_t                       recv;

    integer                 seed;
    int                     errors;
    int                     checks;
    busPkg::busReq_t        expQ[$];  // Acked and not yet granted
    busPkg::busReq_t        expReq;
    int                     grantLog[$];
    int                     expOrder[$];
    agentPkg::senderVec_t   outstanding;
    int                     raisedCount;
    agentPkg::senderVec_t   prevGrant;
    agentPkg::receiverVec_t prevRecv;

    bit autoRelease;
    bit randomRel;
    int relWait;
    int relDelays[64];
    int relIdx;
    int holdCnt;
    int holdTarget;
    bit holdNew;

    `include "busTests.svh"

    busTop i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .reqDest (reqDest),
        .free    (free),
        .rel     (rel),
        .ack     (ack),
        .grant   (grant),
        .recv    (recv)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Requesters drop req once they see their ack
    always @(negedge clk) begin
        for (int i = 0; i < `BUS_NUM_SENDERS; i++) begin
            if (ack[i]) begin
                req[i] = 1'b0;
            end
        end
    end

    // Owner holds the bus for holdTarget cycles, then raises rel until grant falls
    always @(negedge clk) begin
        if (autoRelease) begin
            if (grant == '0) begin
                rel = '0;
                holdCnt = 0;
                holdNew = 1'b1;
            end else begin
                if (holdNew) begin
                    holdNew = 1'b0;
                    holdTarget = randomRel ? relDelays[relIdx % 64] : relWait;
                    relIdx++;
                end
                if (holdCnt >= holdTarget) begin
                    rel = rel | grant;
                end else begin
                    holdCnt++;
                end
            end
        end
    end

    // Reference model, sampled just after each rising edge
    always @(posedge clk) begin
        #1;
        if (rstN) begin
            if (!$onehot0(ack)) begin
                flagError("more than one sender was acknowledged in one cycle");
            end
            for (int i = 0; i < `BUS_NUM_SENDERS; i++) begin
                if (ack[i]) begin
                    expReq.sender = agentPkg::senderId_t'(i);
                    expReq.dest = reqDest[i];
                    expQ.push_back(expReq);
                end
            end
            if (grant == '0) begin
                checkValue("recv", recv, 0);
                outstanding = outstanding & ~prevGrant;  // Transfer finished
            end else if (prevGrant == '0) begin
                if (expQ.size() == 0) begin
                    flagError("a grant rose while no acknowledged request was waiting");
                end else begin
                    expReq = expQ.pop_front();
                    checkValue("grant", grant, 32'd1 << expReq.sender);
                    checkValue("recv", recv, 32'd1 << expReq.dest);
                    if (!free[expReq.dest]) begin
                        flagError("the bus was granted to a receiver that was not free");
                    end
                    grantLog.push_back(oneHotIndex(grant));
                end
            end else begin
                checkValue("grant", grant, prevGrant);
                checkValue("recv", recv, prevRecv);
            end
            prevGrant = grant;
            prevRecv = recv;
        end
    end

    initial begin : watchdog
        #((TestBudget + MarginCycles) * ClkPeriod);
        $display("ERROR: the tests did not finish within %0d cycles",
                 TestBudget + MarginCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        req = '0;
        for (int i = 0; i < `BUS_NUM_SENDERS; i++) begin
            reqDest[i] = agentPkg::rcvIcEven;
        end
        free = '0;
        rel = '0;
        seed = 32'hd3ad7bda;
        errors = 0;
        checks = 0;
        outstanding = '0;
        raisedCount = 0;
        prevGrant = '0;
        prevRecv = '0;
        autoRelease = 1'b0;
        randomRel = 1'b0;
        relWait = 1;
        relIdx = 0;
        holdCnt = 0;
        holdTarget = 0;
        holdNew = 1'b1;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        testReset();
        testSingle();
        testPriority();
        testBusyReceiver();
        testBackPressure();
        testRandom();

        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
+incdir+tb
source/agentPkg.sv
source/busPkg.sv
source/reqQueue.sv
source/reqCollect.sv
source/busArbiter.sv
source/busTop.sv
tb/busTb.sv
